// File: hdl/ahb_pkg.sv
// AHB-Lite bus side, 32-bit only, no lock, protection or burst-length fields, hresp never ERROR
`default_nettype none

package ahb_pkg;

  // Bus widths
  localparam int unsigned AhbAddrWidth = 32;
  localparam int unsigned AhbDataWidth = 32;

  // Transfer type, only NONSEQ and SEQ move data
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Transfer size
  // Anything wider than a word is served as a word
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HALF  = 3'b001,
    HSIZE_WORD  = 3'b010,
    HSIZE_DWORD = 3'b011,
    HSIZE_4W    = 3'b100,
    HSIZE_8W    = 3'b101,
    HSIZE_16W   = 3'b110,
    HSIZE_32W   = 3'b111
  } hsize_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Master to slave
  typedef struct packed {
    htrans_e                 htrans;
    hsize_e                  hsize;
    logic                    hwrite;
    logic [AhbAddrWidth-1:0] haddr;
    logic [AhbDataWidth-1:0] hwdata;
  } ahb_req_t;

  // Slave to master
  typedef struct packed {
    logic                    hready;
    hresp_e                  hresp;
    logic [AhbDataWidth-1:0] hrdata;
  } ahb_resp_t;

endpackage

`default_nettype wire

// File: hdl/spm_pkg.sv
// Four word-interleaved banks of 64 words, address bits above 9 ignored so the image wraps at 1 KiB
`default_nettype none

package spm_pkg;

  // Geometry
  localparam int unsigned NumBanks     = 4;
  localparam int unsigned BankIdxWidth = 2;
  localparam int unsigned RowsPerBank  = 64;
  localparam int unsigned RowWidth     = 6;
  localparam int unsigned ByteOffWidth = 2;

  localparam int unsigned SpmAddrWidth = 32;
  localparam int unsigned SpmDataWidth = 32;
  localparam int unsigned SpmBeWidth   = SpmDataWidth / 8;

  // Address fields, byte lane in [1:0], bank in [3:2], row in [9:4]
  localparam int unsigned BankLsb = ByteOffWidth;
  localparam int unsigned RowLsb  = ByteOffWidth + BankIdxWidth;

  // Single-word request from the adapter
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [SpmBeWidth-1:0]   be;
    logic [SpmAddrWidth-1:0] addr;
    logic [SpmDataWidth-1:0] wdata;
  } spm_req_t;

  typedef logic spm_gnt_t;

  // Read data, valid one cycle after grant
  typedef struct packed {
    logic                    rvalid;
    logic [SpmDataWidth-1:0] rdata;
  } spm_rsp_t;

  // Per-bank request with the row already decoded
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [SpmBeWidth-1:0]   be;
    logic [RowWidth-1:0]     row;
    logic [SpmDataWidth-1:0] wdata;
  } spm_bank_req_t;

endpackage

`default_nettype wire

// File: hdl/spm_bank.sv
// Single-port 64x32 bank, byte-enabled write, read data one cycle after the request
`default_nettype none

module spm_bank (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  spm_pkg::spm_bank_req_t           bank_req_i,
  output logic [spm_pkg::SpmDataWidth-1:0] rdata_o
);

  logic [spm_pkg::SpmDataWidth-1:0] mem_q [spm_pkg::RowsPerBank];
  logic [spm_pkg::SpmDataWidth-1:0] rdata_q;
  logic                             wr_en;
  logic                             rd_en;

  assign wr_en = bank_req_i.req && bank_req_i.we;
  assign rd_en = bank_req_i.req && !bank_req_i.we;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // Only enabled byte lanes change
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int unsigned lane = 0; lane < spm_pkg::SpmBeWidth; lane++) begin
        if (bank_req_i.be[lane]) begin
          mem_q[bank_req_i.row][lane*8 +: 8] <= bank_req_i.wdata[lane*8 +: 8];
        end
      end
    end
  end

  // Read port
  // Holds the last read word between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= mem_q[bank_req_i.row];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hdl/spm_bank_router.sv
// Combinational bank decode, every bank accepts each cycle so grant follows req
`default_nettype none

module spm_bank_router (
  input  spm_pkg::spm_req_t                              spm_req_i,
  output spm_pkg::spm_gnt_t                              spm_gnt_o,
  output spm_pkg::spm_bank_req_t [spm_pkg::NumBanks-1:0] bank_req_o,
  output logic [spm_pkg::NumBanks-1:0]                   rd_accept_o
);

  logic [spm_pkg::BankIdxWidth-1:0] bank_idx;
  logic [spm_pkg::RowWidth-1:0]     row;

  // Word-interleaved, bank bits sit just above the byte lane
  assign bank_idx = spm_req_i.addr[spm_pkg::RowLsb-1:spm_pkg::BankLsb];
  // Bits above the row field are dropped
  assign row      = spm_req_i.addr[spm_pkg::RowLsb+spm_pkg::RowWidth-1:spm_pkg::RowLsb];

  // Single-cycle banks, no stall
  assign spm_gnt_o = spm_req_i.req;

  always_comb begin
    for (int unsigned b = 0; b < spm_pkg::NumBanks; b++) begin
      // Only the addressed bank sees req
      bank_req_o[b].req   = spm_req_i.req &&
                            (bank_idx == spm_pkg::BankIdxWidth'(b));
      bank_req_o[b].we    = spm_req_i.we;
      bank_req_o[b].be    = spm_req_i.be;
      bank_req_o[b].row   = row;
      bank_req_o[b].wdata = spm_req_i.wdata;
      // Mark the bank whose read was granted
      rd_accept_o[b]      = bank_req_o[b].req && !spm_req_i.we && spm_gnt_o;
    end
  end

endmodule

`default_nettype wire

// File: hdl/spm_resp_merge.sv
// Expects at most one bank read per cycle, rvalid one cycle after the accepted read
`default_nettype none

module spm_resp_merge (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic [spm_pkg::NumBanks-1:0]                        rd_accept_i,
  input  logic [spm_pkg::NumBanks-1:0][spm_pkg::SpmDataWidth-1:0] bank_rdata_i,
  output spm_pkg::spm_rsp_t                                   spm_rsp_o
);

  logic [spm_pkg::NumBanks-1:0]     rd_sel_q;
  logic [spm_pkg::SpmDataWidth-1:0] rdata;

  // Which bank was read last cycle, one-hot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_sel_q <= '0;
    end else begin
      rd_sel_q <= rd_accept_i;
    end
  end

  // AND-OR select, zero when nothing was read
  always_comb begin
    rdata = '0;
    for (int unsigned b = 0; b < spm_pkg::NumBanks; b++) begin
      if (rd_sel_q[b]) begin
        rdata = rdata | bank_rdata_i[b];
      end
    end
  end

  assign spm_rsp_o.rvalid = |rd_sel_q;
  assign spm_rsp_o.rdata  = rdata;

endmodule

`default_nettype wire

// File: hdl/ahb_spm_adapter.sv
// One transfer in flight at a time, hresp tied to OKAY, IDLE and BUSY ignored, sizes over word as word
`default_nettype none

module ahb_spm_adapter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ahb_pkg::ahb_req_t  ahb_req_i,
  output ahb_pkg::ahb_resp_t ahb_resp_o,
  output spm_pkg::spm_req_t  spm_req_o,
  input  spm_pkg::spm_gnt_t  spm_gnt_i,
  input  spm_pkg::spm_rsp_t  spm_rsp_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_READ,
    S_READ_DATA
  } state_e;

  state_e state_q;
  state_e state_d;

  logic                                 hready;
  logic [ahb_pkg::AhbDataWidth-1:0]     hrdata;
  logic                                 xfer_req;
  logic [ahb_pkg::AhbAddrWidth-1:0]     addr_q;
  logic [spm_pkg::SpmBeWidth-1:0]       be_q;
  logic                                 we_q;

  // Byte lanes from transfer size and low address bits
  function automatic logic [spm_pkg::SpmBeWidth-1:0] calc_be(
    input ahb_pkg::hsize_e                  size,
    input logic [spm_pkg::ByteOffWidth-1:0] off
  );
    logic [spm_pkg::SpmBeWidth-1:0] be;
    case (size)
      ahb_pkg::HSIZE_BYTE: be = 4'b0001 << off;
      // Halfword always starts at the even lane
      ahb_pkg::HSIZE_HALF: be = 4'b0011 << {off[1], 1'b0};
      default:             be = 4'b1111;
    endcase
    return be;
  endfunction

  // Address phase accepted only while hready is high
  assign xfer_req = hready &&
                    ((ahb_req_i.htrans == ahb_pkg::NONSEQ) ||
                     (ahb_req_i.htrans == ahb_pkg::SEQ));

  // ----------------------------------------
  // State machine
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (xfer_req) begin
          state_d = ahb_req_i.hwrite ? S_WRITE : S_READ;
        end
      end
      // Write done once granted
      S_WRITE: begin
        if (spm_gnt_i) begin
          state_d = S_IDLE;
        end
      end
      S_READ: begin
        if (spm_gnt_i) begin
          state_d = S_READ_DATA;
        end
      end
      // Next address phase may overlap the returning data
      S_READ_DATA: begin
        if (spm_rsp_i.rvalid && xfer_req) begin
          state_d = ahb_req_i.hwrite ? S_WRITE : S_READ;
        end else if (spm_rsp_i.rvalid) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  // ----------------------------------------
  // Address phase capture
  // ----------------------------------------

  // Direction kept with the address, not taken from the next address phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (xfer_req) begin
      we_q <= ahb_req_i.hwrite;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer_req) begin
      addr_q <= ahb_req_i.haddr;
      be_q   <= calc_be(ahb_req_i.hsize, ahb_req_i.haddr[spm_pkg::ByteOffWidth-1:0]);
    end
  end

  // ----------------------------------------
  // Bus and scratchpad outputs
  // ----------------------------------------

  always_comb begin
    hready = 1'b1;
    hrdata = '0;
    case (state_q)
      S_WRITE,
      S_READ: hready = 1'b0;
      S_READ_DATA: begin
        hready = spm_rsp_i.rvalid;
        if (spm_rsp_i.rvalid) begin
          hrdata = spm_rsp_i.rdata;
        end
      end
      default: ;
    endcase
  end

  assign ahb_resp_o.hready = hready;
  assign ahb_resp_o.hresp  = ahb_pkg::OKAY;
  assign ahb_resp_o.hrdata = hrdata;

  // Request held in WRITE and READ until granted
  assign spm_req_o.req   = (state_q == S_WRITE) || (state_q == S_READ);
  assign spm_req_o.we    = we_q;
  assign spm_req_o.be    = be_q;
  assign spm_req_o.addr  = addr_q;
  // Write data arrives in the data phase
  assign spm_req_o.wdata = ahb_req_i.hwdata;

endmodule

`default_nettype wire

// File: hdl/ahb_spm_top.sv
// AHB-Lite scratchpad slave, 1 KiB image in four banks, two-cycle data phase for reads and writes
`default_nettype none

module ahb_spm_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ahb_pkg::ahb_req_t  ahb_req_i,
  output ahb_pkg::ahb_resp_t ahb_resp_o
);

  spm_pkg::spm_req_t                                       spm_req;
  spm_pkg::spm_gnt_t                                       spm_gnt;
  spm_pkg::spm_rsp_t                                       spm_rsp;
  spm_pkg::spm_bank_req_t [spm_pkg::NumBanks-1:0]          bank_req;
  logic [spm_pkg::NumBanks-1:0]                            rd_accept;
  logic [spm_pkg::NumBanks-1:0][spm_pkg::SpmDataWidth-1:0] bank_rdata;

  // Bus side
  ahb_spm_adapter adapter_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ahb_req_i  (ahb_req_i),
    .ahb_resp_o (ahb_resp_o),
    .spm_req_o  (spm_req),
    .spm_gnt_i  (spm_gnt),
    .spm_rsp_i  (spm_rsp)
  );

  // Bank decode
  spm_bank_router router_i (
    .spm_req_i   (spm_req),
    .spm_gnt_o   (spm_gnt),
    .bank_req_o  (bank_req),
    .rd_accept_o (rd_accept)
  );

  // One memory per interleave slot
  for (genvar b = 0; b < spm_pkg::NumBanks; b++) begin : g_bank
    spm_bank bank_i (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .bank_req_i (bank_req[b]),
      .rdata_o    (bank_rdata[b])
    );
  end

  // Read data return
  spm_resp_merge merge_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_accept_i  (rd_accept),
    .bank_rdata_i (bank_rdata),
    .spm_rsp_o    (spm_rsp)
  );

endmodule

`default_nettype wire

// File: testbench/tb_ahb_spm_top.sv
// Single AHB-Lite master reading only words written before since memory starts undefined
`default_nettype none

module tb_ahb_spm_top;

  localparam int   ResetCycles = 8;
  localparam int   IdleCycles  = 4;
  localparam logic WR          = 1'b1;
  localparam logic RD          = 1'b0;

  // One row per bus transfer with zero write data standing for a random word
  typedef struct packed {
    logic             write;
    ahb_pkg::htrans_e htrans;
    ahb_pkg::hsize_e  hsize;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic             pipe;
  } stim_t;

  logic               clk_i;
  logic               rst_ni;
  ahb_pkg::ahb_req_t  ahb_req;
  ahb_pkg::ahb_resp_t ahb_resp;

  stim_t       tbl [$];
  logic [7:0]  shadow [1024];
  logic [31:0] rng;
  int          err_cnt;
  int          chk_cnt;
  int          cycle_cnt;
  int          cycle_limit;

  ahb_spm_top dut_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ahb_req_i  (ahb_req),
    .ahb_resp_o (ahb_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_step(input logic wr, input ahb_pkg::htrans_e tr, input ahb_pkg::hsize_e sz,
                          input logic [31:0] addr, input logic [31:0] data, input logic pipe);
    stim_t s;
    s.write  = wr;
    s.htrans = tr;
    s.hsize  = sz;
    s.addr   = addr;
    s.wdata  = data;
    s.pipe   = pipe;
    tbl.push_back(s);
  endtask

  // ----------------------------------------
  // Byte-lane reference memory
  // ----------------------------------------

  // Lanes follow the size and halfwords start at the even lane
  // Only the low 10 address bits count
  task automatic shadow_write(input logic [31:0] addr, input ahb_pkg::hsize_e size,
                              input logic [31:0] data);
    int first;
    int last;
    case (size)
      ahb_pkg::HSIZE_BYTE: begin
        first = int'(addr[1:0]);
        last  = first;
      end
      ahb_pkg::HSIZE_HALF: begin
        first = addr[1] ? 2 : 0;
        last  = first + 1;
      end
      default: begin
        first = 0;
        last  = 3;
      end
    endcase
    for (int k = first; k <= last; k++) begin
      shadow[{addr[9:2], 2'(k)}] = data[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    logic [9:0] base;
    base = {addr[9:2], 2'b00};
    return {shadow[base + 10'd3], shadow[base + 10'd2], shadow[base + 10'd1], shadow[base]};
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_rdata(input ahb_pkg::ahb_resp_t got, input logic [31:0] exp,
                             input string what);
    chk_cnt++;
    if (got.hrdata !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s, hrdata %h expected %h", $time, what, got.hrdata, exp);
    end
  endtask

  task automatic check_resp(input ahb_pkg::ahb_resp_t got, input logic exp_ready,
                            input string what);
    chk_cnt++;
    if (got.hready !== exp_ready || got.hresp !== ahb_pkg::OKAY) begin
      err_cnt++;
      $display("FAILED at %0t: %s, hready %b hresp %b expected hready %b and OKAY",
               $time, what, got.hready, got.hresp, exp_ready);
    end
  endtask

  // Master side drive called right after a rising edge
  task automatic drive_addr(input stim_t s);
    ahb_req.htrans <= s.htrans;
    ahb_req.hsize  <= s.hsize;
    ahb_req.hwrite <= s.write;
    ahb_req.haddr  <= s.addr;
  endtask

  task automatic drive_idle();
    ahb_req.htrans <= ahb_pkg::IDLE;
    ahb_req.hwrite <= 1'b0;
  endtask

  // Sampled on the falling edge where the response is settled
  task automatic wait_hready();
    while (!ahb_resp.hready) begin
      @(negedge clk_i);
    end
  endtask

  task automatic build_table();
    // Words in all four banks and back-to-back reads of them
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0000, 32'h1111_0000, 1'b0);
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0004, 32'h2222_1111, 1'b1);
    add_step(WR, ahb_pkg::SEQ,    ahb_pkg::HSIZE_WORD, 32'h0000_0008, 32'h0000_0000, 1'b1);
    add_step(WR, ahb_pkg::SEQ,    ahb_pkg::HSIZE_WORD, 32'h0000_000C, 32'h0000_0000, 1'b1);
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0010, 32'h0000_0000, 1'b0);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_step(RD, ahb_pkg::SEQ,    ahb_pkg::HSIZE_WORD, 32'h0000_0004, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::SEQ,    ahb_pkg::HSIZE_WORD, 32'h0000_0008, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::SEQ,    ahb_pkg::HSIZE_WORD, 32'h0000_000C, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0010, 32'h0000_0000, 1'b1);
    // Partial writes including a misaligned halfword
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_BYTE, 32'h0000_0001, 32'hA5A5_5AC3, 1'b0);
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_BYTE, 32'h0000_000E, 32'h0000_0000, 1'b1);
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_HALF, 32'h0000_0006, 32'hBEEF_0000, 1'b1);
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_HALF, 32'h0000_0008, 32'h0000_0000, 1'b1);
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_HALF, 32'h0000_0013, 32'h0000_0000, 1'b0);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_step(RD, ahb_pkg::SEQ,    ahb_pkg::HSIZE_WORD, 32'h0000_0004, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::SEQ,    ahb_pkg::HSIZE_WORD, 32'h0000_0008, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_BYTE, 32'h0000_000D, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_HALF, 32'h0000_0012, 32'h0000_0000, 1'b1);
    // Direction changes without idle cycles
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0020, 32'h0000_0000, 1'b0);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0020, 32'h0000_0000, 1'b1);
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0024, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0024, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0020, 32'h0000_0000, 1'b1);
    // IDLE and BUSY with hwrite set leave memory alone
    add_step(WR, ahb_pkg::IDLE,   ahb_pkg::HSIZE_WORD, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0);
    add_step(WR, ahb_pkg::BUSY,   ahb_pkg::HSIZE_WORD, 32'h0000_0004, 32'hFFFF_FFFF, 1'b1);
    add_step(WR, ahb_pkg::IDLE,   ahb_pkg::HSIZE_WORD, 32'h0000_0020, 32'hFFFF_FFFF, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0004, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0020, 32'h0000_0000, 1'b1);
    // Aliases above 1 KiB
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0400, 32'h0000_0000, 1'b0);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0000, 32'h0000_0000, 1'b1);
    add_step(WR, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'hFFFF_FC30, 32'h0000_0000, 1'b0);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0030, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h0000_0800, 32'h0000_0000, 1'b1);
    add_step(RD, ahb_pkg::NONSEQ, ahb_pkg::HSIZE_WORD, 32'h1234_5010, 32'h0000_0000, 1'b1);
  endtask

  // ----------------------------------------
  // Stimulus and checking
  // ----------------------------------------

  initial begin : stimulus
    stim_t       s;
    logic [31:0] wdata;
    logic        next_pipe;
    logic        is_xfer;
    string       what;
    ahb_req = '0;
    rst_ni  = 1'b0;
    rng     = 32'hb588;
    err_cnt = 0;
    chk_cnt = 0;
    build_table();
    cycle_limit = 12 * tbl.size() + ResetCycles + IdleCycles;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Quiet bus after reset
    repeat (IdleCycles) begin
      @(negedge clk_i);
      check_resp(ahb_resp, 1'b1, "idle bus after reset");
      check_rdata(ahb_resp, '0, "hrdata after reset");
    end
    @(posedge clk_i);
    drive_addr(tbl[0]);
    @(negedge clk_i);
    // Each pass starts on the falling edge of a cycle holding this row's address phase
    for (int i = 0; i < tbl.size(); i++) begin
      s         = tbl[i];
      what      = $sformatf("step %0d addr %h", i, s.addr);
      is_xfer   = (s.htrans == ahb_pkg::NONSEQ) || (s.htrans == ahb_pkg::SEQ);
      next_pipe = (i + 1 < tbl.size()) && tbl[i + 1].pipe;
      wdata     = s.wdata;
      if (s.write && s.wdata == '0) begin
        rng   = xorshift32(rng);
        wdata = rng;
      end
      // Address phase held until hready
      wait_hready();
      @(posedge clk_i);
      ahb_req.hwdata <= wdata;
      // Follow-on address overlaps this data phase
      if (next_pipe) begin
        drive_addr(tbl[i + 1]);
      end else begin
        drive_idle();
      end
      @(negedge clk_i);
      if (is_xfer) begin
        check_resp(ahb_resp, 1'b0, what);
        // Data phase ends in its second cycle
        @(negedge clk_i);
        check_resp(ahb_resp, 1'b1, what);
        if (s.write) begin
          shadow_write(s.addr, s.hsize, wdata);
        end else begin
          check_rdata(ahb_resp, shadow_word(s.addr), what);
        end
      end else begin
        check_resp(ahb_resp, 1'b1, what);
      end
      if (!next_pipe && i + 1 < tbl.size()) begin
        @(posedge clk_i);
        drive_addr(tbl[i + 1]);
        @(negedge clk_i);
      end
    end
    @(posedge clk_i);
    drive_idle();
    repeat (2) @(posedge clk_i);
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Hang guard with a limit from the table length
  initial begin : watchdog
    cycle_cnt = 0;
    do begin
      @(posedge clk_i);
      cycle_cnt++;
    end while (cycle_cnt < cycle_limit);
    $display("Timeout after %0d cycles, the DUT never finished the transfers", cycle_cnt);
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hdl/ahb_pkg.sv
hdl/spm_pkg.sv
hdl/spm_bank.sv
hdl/spm_bank_router.sv
hdl/spm_resp_merge.sv
hdl/ahb_spm_adapter.sv
hdl/ahb_spm_top.sv
testbench/tb_ahb_spm_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_ahb_spm_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "^Simulation finished: PASS$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
